//--- hdl/fifo_defs.svh
// fixed configuration of the single-clock fifo
// include wherever depth, word width or flag thresholds are needed
// all sizes live here, modules carry no parameters

`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// --------------------------------------------------
// storage geometry
// --------------------------------------------------
`define FIFO_DEPTH       16   // number of entries
`define FIFO_ADDR_W      4    // address bits, log2 of depth
`define FIFO_DATA_W      16   // data word width

// --------------------------------------------------
// static flag thresholds, compared against the level
// --------------------------------------------------
`define FIFO_AFULL_VAL   12   // afull when level >= this
`define FIFO_AEMPTY_VAL  4    // aempty when level <= this

`endif

//--- hdl/fifo_pkg.sv
// shared types of the single-clock fifo
// import into any module or interface that carries data, addresses
// or the occupancy level

`default_nettype none

`include "fifo_defs.svh"

package fifo_pkg;

   // --------------------------------------------------
   // payload and addressing
   // --------------------------------------------------
   typedef logic [`FIFO_DATA_W-1:0] data_t;   // one stored word
   typedef logic [`FIFO_ADDR_W-1:0] addr_t;   // storage index

   // --------------------------------------------------
   // occupancy
   // --------------------------------------------------
   // must hold 0 .. FIFO_DEPTH inclusive, hence depth + 1
   typedef logic [$clog2(`FIFO_DEPTH + 1)-1:0] level_t;

endpackage : fifo_pkg

`default_nettype wire

//--- hdl/fifo_mem_if.sv
// link between the write/read controllers and the storage block
// wr side owned by the write controller, rd side by the read controller,
// mem side by the register file which returns rd_data

`timescale 1ns/1ps
`default_nettype none

interface fifo_mem_if
   import fifo_pkg::*;
   ();

   // write port
   logic  wr_en;     // accepted write this cycle
   addr_t wr_addr;
   data_t wr_data;

   // read port
   logic  rd_en;     // accepted read this cycle
   addr_t rd_addr;
   data_t rd_data;   // registered, valid one cycle after rd_en

   modport wr  (output wr_en, output wr_addr, output wr_data);
   modport rd  (output rd_en, output rd_addr, input  rd_data);
   modport mem (input  wr_en, input  wr_addr, input  wr_data,
                input  rd_en, input  rd_addr, output rd_data);

endinterface : fifo_mem_if

`default_nettype wire

//--- hdl/fifo_wr_ctrl.sv
// write side of the fifo
// admits we_i only while not full, drives the storage write port,
// steps the wrapping write address and flags wack / overflow next cycle

`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module fifo_wr_ctrl
   import fifo_pkg::*;
   (
   input  wire logic  pos_clk_i,
   input  wire logic  aresetn_i,
   input  wire logic  we_i,        // write request
   input  wire data_t wdata_i,
   input  wire logic  full_i,      // from occupancy tracker
   output logic       push_o,      // accepted write strobe
   output logic       wack_o,
   output logic       overflow_o,
   fifo_mem_if.wr     mem
   );

   logic  wr_ok;         // request admitted
   addr_t wr_addr_q;
   logic  wack_q;
   logic  overflow_q;

   // --------------------------------------------------
   // admission
   // --------------------------------------------------
   assign wr_ok  = we_i & ~full_i;   // full refuses
   assign push_o = wr_ok;

   // storage write happens on the same edge
   assign mem.wr_en   = wr_ok;
   assign mem.wr_addr = wr_addr_q;
   assign mem.wr_data = wdata_i;

   // --------------------------------------------------
   // write address, wraps at depth - 1
   // --------------------------------------------------
   always_ff @(posedge pos_clk_i or negedge aresetn_i) begin
      if (!aresetn_i) begin
         wr_addr_q <= '0;
      end else if (wr_ok) begin
         if (wr_addr_q == addr_t'(`FIFO_DEPTH - 1)) begin
            wr_addr_q <= '0;
         end else begin
            wr_addr_q <= wr_addr_q + addr_t'(1);
         end
      end
   end

   // --------------------------------------------------
   // one-cycle status pulses
   // --------------------------------------------------
   always_ff @(posedge pos_clk_i or negedge aresetn_i) begin
      if (!aresetn_i) begin
         wack_q     <= 1'b0;
         overflow_q <= 1'b0;
      end else begin
         wack_q     <= wr_ok;
         overflow_q <= we_i & full_i;   // dropped request
      end
   end

   assign wack_o     = wack_q;
   assign overflow_o = overflow_q;

endmodule : fifo_wr_ctrl

`default_nettype wire

//--- hdl/fifo_rd_ctrl.sv
// read side of the fifo
// admits re_i only while not empty, drives the storage read port,
// steps the wrapping read address and flags dvld / underflow next cycle

`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module fifo_rd_ctrl
   import fifo_pkg::*;
   (
   input  wire logic  pos_clk_i,
   input  wire logic  aresetn_i,
   input  wire logic  re_i,        // read request
   input  wire logic  empty_i,     // from occupancy tracker
   output logic       pop_o,       // accepted read strobe
   output logic       dvld_o,
   output logic       underflow_o,
   fifo_mem_if.rd     mem
   );

   logic  rd_ok;          // request admitted
   addr_t rd_addr_q;
   logic  dvld_q;
   logic  underflow_q;

   // --------------------------------------------------
   // admission
   // --------------------------------------------------
   // empty also blocks a read paired with a write into an empty fifo
   assign rd_ok = re_i & ~empty_i;
   assign pop_o = rd_ok;

   assign mem.rd_en   = rd_ok;       // ram registers the word on this edge
   assign mem.rd_addr = rd_addr_q;

   // --------------------------------------------------
   // read address, wraps at depth - 1
   // --------------------------------------------------
   always_ff @(posedge pos_clk_i or negedge aresetn_i) begin
      if (!aresetn_i) begin
         rd_addr_q <= '0;
      end else if (rd_ok) begin
         if (rd_addr_q == addr_t'(`FIFO_DEPTH - 1)) begin
            rd_addr_q <= '0;
         end else begin
            rd_addr_q <= rd_addr_q + addr_t'(1);
         end
      end
   end

   // --------------------------------------------------
   // one-cycle status pulses
   // --------------------------------------------------
   always_ff @(posedge pos_clk_i or negedge aresetn_i) begin
      if (!aresetn_i) begin
         dvld_q      <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         dvld_q      <= rd_ok;          // lines up with ram output register
         underflow_q <= re_i & empty_i; // refused read
      end
   end

   assign dvld_o      = dvld_q;
   assign underflow_o = underflow_q;

endmodule : fifo_rd_ctrl

`default_nettype wire

//--- hdl/fifo_occupancy.sv
// occupancy tracker for the single-clock fifo
// counts accepted pushes and pops, registers the level and the four
// status flags from the same next value so they always agree
// push and pop arrive already gated by the controllers

`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module fifo_occupancy
   import fifo_pkg::*;
   (
   input  wire logic pos_clk_i,
   input  wire logic aresetn_i,
   input  wire logic push_i,    // accepted write
   input  wire logic pop_i,     // accepted read
   output level_t    level_o,
   output logic      full_o,
   output logic      afull_o,
   output logic      empty_o,
   output logic      aempty_o
   );

   level_t level_q;
   level_t level_nxt;
   logic   full_q;
   logic   afull_q;
   logic   empty_q;
   logic   aempty_q;

   // --------------------------------------------------
   // next level
   // --------------------------------------------------
   always_comb begin
      unique case ({push_i, pop_i})
         2'b10:   level_nxt = level_q + level_t'(1);   // push only
         2'b01:   level_nxt = level_q - level_t'(1);   // pop only
         default: level_nxt = level_q;                 // idle or both
      endcase
   end

   // --------------------------------------------------
   // level register
   // --------------------------------------------------
   always_ff @(posedge pos_clk_i or negedge aresetn_i) begin
      if (!aresetn_i) begin
         level_q <= '0;
      end else begin
         level_q <= level_nxt;
      end
   end

   // --------------------------------------------------
   // status flags
   // --------------------------------------------------
   // decoded from level_nxt, not level_q, so no cycle of lag
   always_ff @(posedge pos_clk_i or negedge aresetn_i) begin
      if (!aresetn_i) begin
         full_q   <= 1'b0;
         afull_q  <= 1'b0;
         empty_q  <= 1'b1;   // starts empty
         aempty_q <= 1'b1;
      end else begin
         full_q   <= (level_nxt == level_t'(`FIFO_DEPTH));
         afull_q  <= (level_nxt >= level_t'(`FIFO_AFULL_VAL));
         empty_q  <= (level_nxt == '0);
         aempty_q <= (level_nxt <= level_t'(`FIFO_AEMPTY_VAL));
      end
   end

   // --------------------------------------------------
   // outputs
   // --------------------------------------------------
   assign level_o  = level_q;
   assign full_o   = full_q;
   assign afull_o  = afull_q;
   assign empty_o  = empty_q;
   assign aempty_o = aempty_q;

endmodule : fifo_occupancy

`default_nettype wire

//--- hdl/fifo_ram.sv
// register-file storage behind the fifo controllers
// one write port, one read port with an output register,
// so read data shows up the cycle after rd_en

`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module fifo_ram
   import fifo_pkg::*;
   (
   input  wire logic pos_clk_i,
   fifo_mem_if.mem   mem
   );

   data_t mem_q [`FIFO_DEPTH];   // storage array
   data_t rd_data_q;             // read output register

   // --------------------------------------------------
   // write port
   // --------------------------------------------------
   always_ff @(posedge pos_clk_i) begin
      if (mem.wr_en) begin
         mem_q[mem.wr_addr] <= mem.wr_data;
      end
   end

   // --------------------------------------------------
   // read port
   // --------------------------------------------------
   // holds last word when idle
   always_ff @(posedge pos_clk_i) begin
      if (mem.rd_en) begin
         rd_data_q <= mem_q[mem.rd_addr];
      end
   end

   assign mem.rd_data = rd_data_q;

endmodule : fifo_ram

`default_nettype wire

//--- hdl/sync_fifo.sv
// single-clock fifo, top level
// write and read controllers around a shared occupancy tracker and
// a register-file storage block; all outputs registered
// requests are refused when full / empty and reported as error pulses

`timescale 1ns/1ps
`default_nettype none

module sync_fifo
   import fifo_pkg::*;
   (
   input  wire logic  pos_clk_i,
   input  wire logic  aresetn_i,
   // write side
   input  wire logic  we_i,
   input  wire data_t wdata_i,
   // read side
   input  wire logic  re_i,
   output data_t      rdata_o,
   // handshake and errors
   output logic       wack_o,
   output logic       dvld_o,
   output logic       overflow_o,
   output logic       underflow_o,
   // status
   output logic       full_o,
   output logic       afull_o,
   output logic       empty_o,
   output logic       aempty_o,
   output level_t     level_o
   );

   logic push;   // accepted write
   logic pop;    // accepted read

   // --------------------------------------------------
   // storage link
   // --------------------------------------------------
   fifo_mem_if u_mem_if ();

   // --------------------------------------------------
   // controllers
   // --------------------------------------------------
   fifo_wr_ctrl u_wr_ctrl (
      .pos_clk_i  (pos_clk_i),
      .aresetn_i  (aresetn_i),
      .we_i       (we_i),
      .wdata_i    (wdata_i),
      .full_i     (full_o),       // fed back from tracker
      .push_o     (push),
      .wack_o     (wack_o),
      .overflow_o (overflow_o),
      .mem        (u_mem_if.wr)
   );

   fifo_rd_ctrl u_rd_ctrl (
      .pos_clk_i   (pos_clk_i),
      .aresetn_i   (aresetn_i),
      .re_i        (re_i),
      .empty_i     (empty_o),     // fed back from tracker
      .pop_o       (pop),
      .dvld_o      (dvld_o),
      .underflow_o (underflow_o),
      .mem         (u_mem_if.rd)
   );

   // --------------------------------------------------
   // level and flags
   // --------------------------------------------------
   fifo_occupancy u_occupancy (
      .pos_clk_i (pos_clk_i),
      .aresetn_i (aresetn_i),
      .push_i    (push),
      .pop_i     (pop),
      .level_o   (level_o),
      .full_o    (full_o),
      .afull_o   (afull_o),
      .empty_o   (empty_o),
      .aempty_o  (aempty_o)
   );

   // storage, read data straight from its output register
   fifo_ram u_ram (
      .pos_clk_i (pos_clk_i),
      .mem       (u_mem_if.mem)
   );

   assign rdata_o = u_mem_if.rd_data;

endmodule : sync_fifo

`default_nettype wire

//--- dv/sync_fifo_tb.sv
// testbench for the single-clock fifo
// replays dv/sync_fifo_trace.txt one line per clock, inputs driven on the
// falling edge, outputs checked at the next falling edge against the trace
// run from the project root so the trace path resolves

`timescale 1ns/1ps
`default_nettype none

module sync_fifo_tb
   import fifo_pkg::*;
   ();

   localparam TRACE_FILE = "dv/sync_fifo_trace.txt";
   localparam int MAX_CYCLES = 200;   // trace lines allowed before giving up
   localparam int RESET_WAIT = 10;    // cycles to see the empty state

   // --------------------------------------------------
   // DUT signals
   // --------------------------------------------------
   logic   pos_clk;
   logic   aresetn;
   logic   we;
   data_t  wdata;
   logic   re;
   data_t  rdata;
   logic   wack;
   logic   dvld;
   logic   overflow;
   logic   underflow;
   logic   full;
   logic   afull;
   logic   empty;
   logic   aempty;
   level_t level;

   int err_cnt;   // failed checks and other failures
   int chk_cnt;   // compares done

   // 100 ns period
   initial pos_clk = 1'b0;
   always #50 pos_clk = ~pos_clk;

   sync_fifo u_dut (
      .pos_clk_i   (pos_clk),
      .aresetn_i   (aresetn),
      .we_i        (we),
      .wdata_i     (wdata),
      .re_i        (re),
      .rdata_o     (rdata),
      .wack_o      (wack),
      .dvld_o      (dvld),
      .overflow_o  (overflow),
      .underflow_o (underflow),
      .full_o      (full),
      .afull_o     (afull),
      .empty_o     (empty),
      .aempty_o    (aempty),
      .level_o     (level)
   );

   // one output field against its trace value, x counts as wrong
   task automatic compare_field(input logic [8*16-1:0] tag, input logic [8*10-1:0] field,
                                input logic [15:0] exp_val, input logic [15:0] act_val);
      chk_cnt++;
      if (act_val !== exp_val) begin
         $display("Fail %0s %0s: expected %h, actual %h", tag, field, exp_val, act_val);
         err_cnt++;
      end
   endtask

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial begin
      integer           fd;
      integer           n;
      integer           cycles;
      integer           waited;
      logic [8*128-1:0] line_buf;
      logic [8*16-1:0]  tag;          // behavior name, first column
      logic [15:0]      t_we;
      logic [15:0]      t_re;
      logic [15:0]      t_wdata;
      logic [15:0]      e_full;
      logic [15:0]      e_afull;
      logic [15:0]      e_empty;
      logic [15:0]      e_aempty;
      logic [15:0]      e_level;
      logic [15:0]      e_wack;
      logic [15:0]      e_dvld;
      logic [15:0]      e_ovf;
      logic [15:0]      e_unf;
      logic [15:0]      e_rdata;

      err_cnt = 0;
      chk_cnt = 0;
      aresetn = 1'b0;
      we      = 1'b0;
      re      = 1'b0;
      wdata   = '0;

      // two clocks of reset, released on a falling edge
      repeat (2) @(posedge pos_clk);
      @(negedge pos_clk);
      aresetn = 1'b1;

      waited = 0;
      while (empty !== 1'b1 && waited < RESET_WAIT) begin
         @(negedge pos_clk);
         waited++;
      end
      if (empty !== 1'b1) begin
         $display("timeout: DUT never showed the empty state after reset");
         err_cnt++;
      end

      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0) begin
         $display("could not open the trace file %0s", TRACE_FILE);
         err_cnt++;
      end else begin
         cycles = 0;
         while (!$feof(fd) && cycles < MAX_CYCLES) begin
            line_buf = '0;
            n = $fgets(line_buf, fd);
            if (n > 0) begin
               n = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           tag, t_we, t_re, t_wdata, e_full, e_afull, e_empty,
                           e_aempty, e_level, e_wack, e_dvld, e_ovf, e_unf, e_rdata);
               if (n == 14) begin
                  we    = t_we[0];     // still on a falling edge here
                  re    = t_re[0];
                  wdata = t_wdata;
                  @(negedge pos_clk);  // one rising edge later
                  cycles++;
                  compare_field(tag, "full", e_full, full);
                  compare_field(tag, "afull", e_afull, afull);
                  compare_field(tag, "empty", e_empty, empty);
                  compare_field(tag, "aempty", e_aempty, aempty);
                  compare_field(tag, "level", e_level, level);
                  compare_field(tag, "wack", e_wack, wack);
                  compare_field(tag, "dvld", e_dvld, dvld);
                  compare_field(tag, "overflow", e_ovf, overflow);
                  compare_field(tag, "underflow", e_unf, underflow);
                  if (e_dvld[0]) begin
                     compare_field(tag, "rdata", e_rdata, rdata);   // only with valid data
                  end
               end else if (n > 0 && tag != "#") begin
                  $display("trace line could not be parsed: %0s", line_buf);
                  err_cnt++;
               end
            end
         end
         if (!$feof(fd)) begin
            $display("timeout: trace still not finished after %0d cycles", cycles);
            err_cnt++;
         end
         $fclose(fd);
      end

      we = 1'b0;
      re = 1'b0;

      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule : sync_fifo_tb

`default_nettype wire

//--- dv/sync_fifo_trace.txt
# test we re wdata | full afull empty aempty level wack dvld ovf unf rdata
# one line per clock, hex values, outputs as seen after the rising edge
reset 0 0 0000 0 0 1 1 00 0 0 0 0 0000
fill 1 0 a5c0 0 0 0 1 01 1 0 0 0 0000
fill 1 0 a5c1 0 0 0 1 02 1 0 0 0 0000
fill 1 0 a5c2 0 0 0 1 03 1 0 0 0 0000
fill 1 0 a5c3 0 0 0 1 04 1 0 0 0 0000
fill 1 0 a5c4 0 0 0 0 05 1 0 0 0 0000
fill 1 0 a5c5 0 0 0 0 06 1 0 0 0 0000
fill 1 0 a5c6 0 0 0 0 07 1 0 0 0 0000
fill 1 0 a5c7 0 0 0 0 08 1 0 0 0 0000
fill 1 0 a5c8 0 0 0 0 09 1 0 0 0 0000
fill 1 0 a5c9 0 0 0 0 0a 1 0 0 0 0000
fill 1 0 a5ca 0 0 0 0 0b 1 0 0 0 0000
fill 1 0 a5cb 0 1 0 0 0c 1 0 0 0 0000
fill 1 0 a5cc 0 1 0 0 0d 1 0 0 0 0000
fill 1 0 a5cd 0 1 0 0 0e 1 0 0 0 0000
fill 1 0 a5ce 0 1 0 0 0f 1 0 0 0 0000
fill 1 0 a5cf 1 1 0 0 10 1 0 0 0 0000
overflow 1 0 dead 1 1 0 0 10 0 0 1 0 0000
drain 0 1 0000 0 1 0 0 0f 0 1 0 0 a5c0
drain 0 1 0000 0 1 0 0 0e 0 1 0 0 a5c1
drain 0 1 0000 0 1 0 0 0d 0 1 0 0 a5c2
drain 0 1 0000 0 1 0 0 0c 0 1 0 0 a5c3
drain 0 1 0000 0 0 0 0 0b 0 1 0 0 a5c4
drain 0 1 0000 0 0 0 0 0a 0 1 0 0 a5c5
drain 0 1 0000 0 0 0 0 09 0 1 0 0 a5c6
drain 0 1 0000 0 0 0 0 08 0 1 0 0 a5c7
wr_rd 1 1 3b10 0 0 0 0 08 1 1 0 0 a5c8
wr_rd 1 1 3b11 0 0 0 0 08 1 1 0 0 a5c9
wr_rd 1 1 3b12 0 0 0 0 08 1 1 0 0 a5ca
wr_rd 1 1 3b13 0 0 0 0 08 1 1 0 0 a5cb
drain 0 1 0000 0 0 0 0 07 0 1 0 0 a5cc
drain 0 1 0000 0 0 0 0 06 0 1 0 0 a5cd
drain 0 1 0000 0 0 0 0 05 0 1 0 0 a5ce
drain 0 1 0000 0 0 0 1 04 0 1 0 0 a5cf
drain 0 1 0000 0 0 0 1 03 0 1 0 0 3b10
drain 0 1 0000 0 0 0 1 02 0 1 0 0 3b11
drain 0 1 0000 0 0 0 1 01 0 1 0 0 3b12
drain 0 1 0000 0 0 1 1 00 0 1 0 0 3b13
underflow 0 1 0000 0 0 1 1 00 0 0 0 1 0000
wr_rd_empty 1 1 7e01 0 0 0 1 01 1 0 0 1 0000
drain 0 1 0000 0 0 1 1 00 0 1 0 0 7e01

//--- flist.f
+incdir+hdl
hdl/fifo_pkg.sv
hdl/fifo_mem_if.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_rd_ctrl.sv
hdl/fifo_occupancy.sv
hdl/fifo_ram.sv
hdl/sync_fifo.sv
dv/sync_fifo_tb.sv

//--- Bender.yml
package:
  name: sync_fifo

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fifo_pkg.sv
      - hdl/fifo_mem_if.sv
      - hdl/fifo_wr_ctrl.sv
      - hdl/fifo_rd_ctrl.sv
      - hdl/fifo_occupancy.sv
      - hdl/fifo_ram.sv
      - hdl/sync_fifo.sv
  - target: test
    files:
      - dv/sync_fifo_tb.sv
